// File: rtl/iob_soc_pkg.sv
package iob_soc_pkg;

   // default bus widths, overridden by the top level parameters
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;

   // internal sram depth in words
   localparam int SRAM_ADDR_W = 8;

   // byte address to word index shift
   localparam int WORD_OFFSET = 2;

   // address map
   // the top address bit selects the slave:
   //   0 -> internal sram
   //   1 -> register peripheral
   // the splitter clears that bit before passing the address on
   typedef enum logic {
      SEL_SRAM = 1'b0,
      SEL_REGS = 1'b1
   } bus_sel_t;

   // register peripheral word map, address bits 3:2
   //   0x0 scratch 0
   //   0x4 scratch 1
   //   0x8 scratch 2
   //   0xc accumulator, a write adds wdata
   typedef enum logic [1:0] {
      REG_SCR0 = 2'd0,
      REG_SCR1 = 2'd1,
      REG_SCR2 = 2'd2,
      REG_ACC  = 2'd3
   } reg_idx_t;

endpackage

// File: rtl/iob_bus_if.sv
`timescale 1ns/1ps

// iob native bus
// a zero wstrb marks a read, reads get one rvalid pulse, writes none
interface iob_bus_if #(
   parameter int ADDR_W = iob_soc_pkg::ADDR_W,
   parameter int DATA_W = iob_soc_pkg::DATA_W
);

   // request, driven by the master
   logic                  valid;
   logic [ADDR_W-1:0]     addr;
   logic [DATA_W-1:0]     wdata;
   logic [DATA_W/8-1:0]   wstrb;

   // handshake and response, driven by the slave
   logic                  ready;
   logic                  rvalid;
   logic [DATA_W-1:0]     rdata;

   modport master (
      output valid, addr, wdata, wstrb,
      input  ready, rvalid, rdata
   );

   modport slave (
      input  valid, addr, wdata, wstrb,
      output ready, rvalid, rdata
   );

endinterface

// File: rtl/iob_req_buf.sv
`timescale 1ns/1ps

module iob_req_buf #(
   parameter int ADDR_W = iob_soc_pkg::ADDR_W,
   parameter int DATA_W = iob_soc_pkg::DATA_W
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                valid_i,
   input  logic [ADDR_W-1:0]   addr_i,
   input  logic [DATA_W-1:0]   wdata_i,
   input  logic [DATA_W/8-1:0] wstrb_i,
   output logic                ready_o,
   iob_bus_if.master           m
);

   // entry storage, two slots
   logic [ADDR_W-1:0]   addr_q  [2];
   logic [DATA_W-1:0]   wdata_q [2];
   logic [DATA_W/8-1:0] wstrb_q [2];

   logic       wr_ptr_q;
   logic       rd_ptr_q;
   logic [1:0] count_q;

   logic push;
   logic pop;

   // room for a new entry while not full
   assign ready_o = (count_q != 2'd2);

   assign push = valid_i && ready_o;
   assign pop  = m.valid && m.ready;

   // head entry goes straight to the splitter
   assign m.valid = (count_q != 2'd0);
   assign m.addr  = addr_q[rd_ptr_q];
   assign m.wdata = wdata_q[rd_ptr_q];
   assign m.wstrb = wstrb_q[rd_ptr_q];

   always_ff @(posedge clk_i) begin
      if (push) begin
         addr_q[wr_ptr_q]  <= addr_i;
         wdata_q[wr_ptr_q] <= wdata_i;
         wstrb_q[wr_ptr_q] <= wstrb_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
         count_q  <= 2'd0;
      end else begin
         if (push) begin
            wr_ptr_q <= ~wr_ptr_q;
         end
         if (pop) begin
            rd_ptr_q <= ~rd_ptr_q;
         end
         // push and pop together keep the count
         case ({push, pop})
            2'b10:   count_q <= count_q + 2'd1;
            2'b01:   count_q <= count_q - 2'd1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

// File: rtl/iob_split.sv
`timescale 1ns/1ps

module iob_split
   import iob_soc_pkg::*;
#(
   parameter int ADDR_W = iob_soc_pkg::ADDR_W,
   parameter int DATA_W = iob_soc_pkg::DATA_W
) (
   input  logic      clk_i,
   input  logic      rst_n_i,
   iob_bus_if.slave  s,
   iob_bus_if.master m_sram,
   iob_bus_if.master m_regs
);

   bus_sel_t          sel;
   bus_sel_t          rd_sel_q;
   logic              rd_pend_q;
   logic              rd_accept;
   logic [ADDR_W-1:0] slv_addr;

   // top address bit picks the slave
   assign sel = bus_sel_t'(s.addr[ADDR_W-1]);

   // slaves see the address without the select bit
   assign slv_addr = {1'b0, s.addr[ADDR_W-2:0]};

   assign m_sram.valid = s.valid && (sel == SEL_SRAM);
   assign m_sram.addr  = slv_addr;
   assign m_sram.wdata = s.wdata;
   assign m_sram.wstrb = s.wstrb;

   assign m_regs.valid = s.valid && (sel == SEL_REGS);
   assign m_regs.addr  = slv_addr;
   assign m_regs.wdata = s.wdata;
   assign m_regs.wstrb = s.wstrb;

   // stall comes from the addressed slave only
   assign s.ready = (sel == SEL_SRAM) ? m_sram.ready : m_regs.ready;

   assign rd_accept = s.valid && s.ready && (s.wstrb == '0);

   // remember who owes the next response
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rd_pend_q <= 1'b0;
         rd_sel_q  <= SEL_SRAM;
      end else begin
         rd_pend_q <= rd_accept;
         if (rd_accept) begin
            rd_sel_q <= sel;
         end
      end
   end

   // response merge, steered by the latched select
   always_comb begin
      if (rd_sel_q == SEL_SRAM) begin
         s.rvalid = rd_pend_q && m_sram.rvalid;
         s.rdata  = m_sram.rdata;
      end else begin
         s.rvalid = rd_pend_q && m_regs.rvalid;
         s.rdata  = m_regs.rdata;
      end
   end

endmodule

// File: rtl/iob_int_sram.sv
`timescale 1ns/1ps

module iob_int_sram
   import iob_soc_pkg::*;
#(
   parameter int DATA_W      = iob_soc_pkg::DATA_W,
   parameter int SRAM_ADDR_W = iob_soc_pkg::SRAM_ADDR_W
) (
   input  logic     clk_i,
   input  logic     rst_n_i,
   iob_bus_if.slave s
);

   logic [DATA_W-1:0] mem [2**SRAM_ADDR_W];

   logic [SRAM_ADDR_W-1:0] word_addr;
   logic                   accept;
   logic                   wr_en;
   logic                   rd_en;
   logic                   rec_q;
   logic                   rvalid_q;
   logic [DATA_W-1:0]      rdata_q;

   assign word_addr = s.addr[WORD_OFFSET +: SRAM_ADDR_W];

   // one dead cycle after every write
   assign s.ready = ~rec_q;

   assign accept = s.valid && s.ready;
   assign wr_en  = accept && (s.wstrb != '0);
   assign rd_en  = accept && (s.wstrb == '0);

   assign s.rvalid = rvalid_q;
   assign s.rdata  = rdata_q;

   // byte lane writes and registered read port
   always_ff @(posedge clk_i) begin
      for (int b = 0; b < DATA_W/8; b++) begin
         if (wr_en && s.wstrb[b]) begin
            mem[word_addr][8*b +: 8] <= s.wdata[8*b +: 8];
         end
      end
      if (rd_en) begin
         rdata_q <= mem[word_addr];
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rec_q    <= 1'b0;
         rvalid_q <= 1'b0;
      end else begin
         rec_q    <= wr_en;
         rvalid_q <= rd_en;
      end
   end

endmodule

// File: rtl/iob_regs.sv
`timescale 1ns/1ps

module iob_regs
   import iob_soc_pkg::*;
#(
   parameter int DATA_W = iob_soc_pkg::DATA_W
) (
   input  logic     clk_i,
   input  logic     rst_n_i,
   iob_bus_if.slave s
);

   reg_idx_t          idx;
   logic              accept;
   logic              wr_en;
   logic              rd_en;
   logic [DATA_W-1:0] scr_q [3];
   logic [DATA_W-1:0] acc_q;
   logic [DATA_W-1:0] rd_mux;
   logic              rvalid_q;
   logic [DATA_W-1:0] rdata_q;

   assign idx = reg_idx_t'(s.addr[WORD_OFFSET +: 2]);

   // never stalls
   assign s.ready = 1'b1;

   assign accept = s.valid && s.ready;
   assign wr_en  = accept && (s.wstrb != '0);
   assign rd_en  = accept && (s.wstrb == '0);

   assign s.rvalid = rvalid_q;
   assign s.rdata  = rdata_q;

   always_comb begin
      case (idx)
         REG_SCR0: rd_mux = scr_q[0];
         REG_SCR1: rd_mux = scr_q[1];
         REG_SCR2: rd_mux = scr_q[2];
         default:  rd_mux = acc_q;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         scr_q[0] <= '0;
         scr_q[1] <= '0;
         scr_q[2] <= '0;
         acc_q    <= '0;
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_en;
         if (wr_en) begin
            if (idx == REG_ACC) begin
               // full word add, strobes ignored, wraps
               acc_q <= acc_q + s.wdata;
            end else begin
               for (int b = 0; b < DATA_W/8; b++) begin
                  if (s.wstrb[b]) begin
                     scr_q[idx][8*b +: 8] <= s.wdata[8*b +: 8];
                  end
               end
            end
         end
      end
   end

   // read data holds until the next read
   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_q <= rd_mux;
      end
   end

endmodule

// File: rtl/iob_soc_sys.sv
`timescale 1ns/1ps

module iob_soc_sys #(
   parameter int ADDR_W      = iob_soc_pkg::ADDR_W,
   parameter int DATA_W      = iob_soc_pkg::DATA_W,
   parameter int SRAM_ADDR_W = iob_soc_pkg::SRAM_ADDR_W
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                iob_valid_i,
   input  logic [ADDR_W-1:0]   iob_addr_i,
   input  logic [DATA_W-1:0]   iob_wdata_i,
   input  logic [DATA_W/8-1:0] iob_wstrb_i,
   output logic                iob_ready_o,
   output logic                iob_rvalid_o,
   output logic [DATA_W-1:0]   iob_rdata_o
);

   iob_bus_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) buf_bus ();
   iob_bus_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) sram_bus ();
   iob_bus_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) regs_bus ();

   // request queue in front of the splitter
   iob_req_buf #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) req_buf (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .valid_i(iob_valid_i),
      .addr_i (iob_addr_i),
      .wdata_i(iob_wdata_i),
      .wstrb_i(iob_wstrb_i),
      .ready_o(iob_ready_o),
      .m      (buf_bus.master)
   );

   iob_split #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
   ) pbus_split (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .s      (buf_bus.slave),
      .m_sram (sram_bus.master),
      .m_regs (regs_bus.master)
   );

   iob_int_sram #(
      .DATA_W     (DATA_W),
      .SRAM_ADDR_W(SRAM_ADDR_W)
   ) int_sram (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .s      (sram_bus.slave)
   );

   iob_regs #(
      .DATA_W(DATA_W)
   ) regs0 (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .s      (regs_bus.slave)
   );

   // responses skip the request queue
   assign iob_rvalid_o = buf_bus.rvalid;
   assign iob_rdata_o  = buf_bus.rdata;

endmodule

// File: sim/iob_soc_checker.sv
`timescale 1ns/1ps

module iob_soc_checker
   import iob_soc_pkg::*;
#(
   parameter int ADDR_W      = iob_soc_pkg::ADDR_W,
   parameter int DATA_W      = iob_soc_pkg::DATA_W,
   parameter int SRAM_ADDR_W = iob_soc_pkg::SRAM_ADDR_W
) (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                valid_i,
   input  logic [ADDR_W-1:0]   addr_i,
   input  logic [DATA_W-1:0]   wdata_i,
   input  logic [DATA_W/8-1:0] wstrb_i,
   input  logic                ready_i,
   input  logic                rvalid_i,
   input  logic [DATA_W-1:0]   rdata_i,
   output int                  err_cnt_o,
   output int                  rd_cnt_o,
   output int                  pend_o
);

   // reference state
   logic [DATA_W-1:0] sram_m [int];
   logic [DATA_W-1:0] scr_m  [3];
   logic [DATA_W-1:0] acc_m;

   // expected read data and address per outstanding read
   logic [DATA_W-1:0] exp_q  [$];
   logic [ADDR_W-1:0] addr_q [$];

   function automatic logic [DATA_W-1:0] merge_bytes(
      input logic [DATA_W-1:0]   old_w,
      input logic [DATA_W-1:0]   new_w,
      input logic [DATA_W/8-1:0] strb
   );
      logic [DATA_W-1:0] res;
      res = old_w;
      for (int b = 0; b < DATA_W/8; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   always @(posedge clk_i) begin : watch
      bus_sel_t          sel;
      reg_idx_t          idx;
      int                word;
      logic [DATA_W-1:0] old_w;
      logic [DATA_W-1:0] exp_w;
      logic [ADDR_W-1:0] exp_a;
      // no request taken since reset
      logic              fresh;
      if (!rst_n_i) begin
         scr_m[0] = '0;
         scr_m[1] = '0;
         scr_m[2] = '0;
         acc_m    = '0;
         fresh    = 1'b1;
         exp_q.delete();
         addr_q.delete();
      end else begin
         // an empty buffer always has room
         if (fresh && (ready_i !== 1'b1)) begin
            $display("ERROR @ %0t: iob_ready_o is %b with the buffer empty after reset",
                     $time, ready_i);
            err_cnt_o++;
         end
         // a response belongs to the oldest read
         if (rvalid_i) begin
            if (exp_q.size() == 0) begin
               $display("unexpected read response at %0t with no read outstanding", $time);
               err_cnt_o++;
            end else begin
               exp_w = exp_q.pop_front();
               exp_a = addr_q.pop_front();
               rd_cnt_o++;
               if (rdata_i !== exp_w) begin
                  $display("ERROR @ %0t: addr %h expected %h seen %h",
                           $time, exp_a, exp_w, rdata_i);
                  err_cnt_o++;
               end
            end
         end
         if (valid_i && ready_i) begin
            fresh = 1'b0;
            sel  = bus_sel_t'(addr_i[ADDR_W-1]);
            idx  = reg_idx_t'(addr_i[3:2]);
            word = int'(addr_i[2 +: SRAM_ADDR_W]);
            old_w = sram_m.exists(word) ? sram_m[word] : 'x;
            if (wstrb_i != '0) begin
               if (sel == SEL_SRAM) begin
                  sram_m[word] = merge_bytes(old_w, wdata_i, wstrb_i);
               end else if (idx == REG_ACC) begin
                  acc_m = acc_m + wdata_i;
               end else begin
                  scr_m[idx] = merge_bytes(scr_m[idx], wdata_i, wstrb_i);
               end
            end else begin
               if (sel == SEL_SRAM) begin
                  exp_q.push_back(old_w);
               end else begin
                  exp_q.push_back((idx == REG_ACC) ? acc_m : scr_m[idx]);
               end
               addr_q.push_back(addr_i);
            end
         end
      end
      pend_o = exp_q.size();
   end

endmodule

// File: sim/tb_iob_soc_sys.sv
`timescale 1ns/1ps

module tb_iob_soc_sys
   import iob_soc_pkg::*;
();

   localparam int SEED       = 51;
   localparam int NUM_READS  = 32;
   localparam int BURST_LEN  = 64;
   localparam int TIMEOUT    = 100;
   localparam int SRAM_WORDS = 2**SRAM_ADDR_W;

   logic                clk;
   logic                rst_n;
   logic                valid;
   logic [ADDR_W-1:0]   addr;
   logic [DATA_W-1:0]   wdata;
   logic [DATA_W/8-1:0] wstrb;
   logic                ready;
   logic                rvalid;
   logic [DATA_W-1:0]   rdata;
   int                  err_cnt;
   int                  rd_cnt;
   int                  pend;
   int                  err_mark;
   integer              seed;

   iob_soc_sys #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .SRAM_ADDR_W(SRAM_ADDR_W)) DUT (
      .clk_i(clk), .rst_n_i(rst_n),
      .iob_valid_i(valid), .iob_addr_i(addr), .iob_wdata_i(wdata), .iob_wstrb_i(wstrb),
      .iob_ready_o(ready), .iob_rvalid_o(rvalid), .iob_rdata_o(rdata)
   );

   iob_soc_checker #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .SRAM_ADDR_W(SRAM_ADDR_W)) resp_check (
      .clk_i(clk), .rst_n_i(rst_n),
      .valid_i(valid), .addr_i(addr), .wdata_i(wdata), .wstrb_i(wstrb),
      .ready_i(ready), .rvalid_i(rvalid), .rdata_i(rdata),
      .err_cnt_o(err_cnt), .rd_cnt_o(rd_cnt), .pend_o(pend)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [ADDR_W-1:0] sram_addr(input int word);
      return ADDR_W'(word) << 2;
   endfunction

   function automatic logic [ADDR_W-1:0] reg_addr(input int idx);
      return (ADDR_W'(1) << (ADDR_W-1)) | (ADDR_W'(idx) << 2);
   endfunction

   // random strobe, never all zero
   function automatic logic [DATA_W/8-1:0] rand_strobe();
      logic [DATA_W/8-1:0] s;
      s = $random(seed);
      return (s == '0) ? {(DATA_W/8){1'b1}} : s;
   endfunction

   task automatic stop_on_timeout(input string what);
      $display("timeout while waiting for %s", what);
      $display("*** TEST FAILED ***");
      $finish;
   endtask

   // called on a rising edge, returns on the edge that takes the request
   task automatic send(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                       input logic [DATA_W/8-1:0] s);
      int waited;
      waited = 0;
      valid <= 1'b1;
      addr  <= a;
      wdata <= d;
      wstrb <= s;
      do begin
         @(negedge clk);
         waited++;
         if (waited > TIMEOUT) stop_on_timeout("iob_ready_o");
      end while (!ready);
      @(posedge clk);
   endtask

   task automatic drain();
      int waited;
      valid <= 1'b0;
      wstrb <= '0;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
         if (waited > TIMEOUT) stop_on_timeout("outstanding read responses");
      end while (pend != 0);
      @(posedge clk);
   endtask

   task automatic report(input int num, input string name);
      $display("test %0d (%s) finished with %0d errors", num, name, err_cnt - err_mark);
      err_mark = err_cnt;
   endtask

   initial begin : stimulus
      int                word;
      logic [31:0]       r;
      logic [ADDR_W-1:0] a;
      seed     = SEED;
      err_mark = 0;
      rst_n    = 1'b0;
      valid    = 1'b0;
      addr     = '0;
      wdata    = '0;
      wstrb    = '0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);

      // fill every sram word, then read some back
      for (int w = 0; w < SRAM_WORDS; w++) send(sram_addr(w), $random(seed), '1);
      for (int i = 0; i < NUM_READS; i++) begin
         word = $random(seed) & (SRAM_WORDS-1);
         send(sram_addr(word), '0, '0);
      end
      drain();
      report(1, "sram full words");

      for (int i = 0; i < NUM_READS; i++) begin
         word = $random(seed) & (SRAM_WORDS-1);
         send(sram_addr(word), $random(seed), rand_strobe());
         send(sram_addr(word), '0, '0);
      end
      drain();
      report(2, "sram byte strobes");

      for (int i = 0; i < 12; i++) begin
         send(reg_addr(i % 3), $random(seed), rand_strobe());
         send(reg_addr(i % 3), '0, '0);
      end
      // accumulator adds the whole word whatever the strobe
      for (int i = 0; i < 8; i++) send(reg_addr(REG_ACC), $random(seed), rand_strobe());
      send(reg_addr(REG_ACC), '0, '0);
      drain();
      report(3, "registers and accumulator");

      // valid stays high for the whole burst
      for (int i = 0; i < BURST_LEN; i++) begin
         r = $random(seed);
         word = r[31:8] & (SRAM_WORDS-1);
         a = r[0] ? reg_addr(r[5:4]) : sram_addr(word);
         send(a, $random(seed), r[1] ? '0 : rand_strobe());
      end
      drain();
      report(4, "mixed burst");

      rst_n <= 1'b0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      // quiet bus, a stray rvalid is flagged by the checker
      repeat (4) @(posedge clk);
      for (int i = 0; i < 4; i++) send(reg_addr(i), '0, '0);
      drain();
      report(5, "state after reset");

      $display("tests 5, reads checked %0d, errors %0d", rd_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// File: sources.f
rtl/iob_soc_pkg.sv
rtl/iob_bus_if.sv
rtl/iob_req_buf.sv
rtl/iob_split.sv
rtl/iob_int_sram.sv
rtl/iob_regs.sv
rtl/iob_soc_sys.sv
sim/iob_soc_checker.sv
sim/tb_iob_soc_sys.sv

// File: Bender.yml
package:
  name: iob_soc_sys

sources:
  - rtl/iob_soc_pkg.sv
  - rtl/iob_bus_if.sv
  - rtl/iob_req_buf.sv
  - rtl/iob_split.sv
  - rtl/iob_int_sram.sv
  - rtl/iob_regs.sv
  - rtl/iob_soc_sys.sv
  - target: simulation
    files:
      - sim/iob_soc_checker.sv
      - sim/tb_iob_soc_sys.sv
